// ==== filelist.f ====
+incdir+source
source/nandCommandPkg.sv
source/nandArrayPkg.sv
source/nandCommandIf.sv
source/commandLatchDecoder.sv
source/lunBusyTracker.sv
source/lunProtocolChecker.sv
source/nandTarget.sv
verification/nandTargetTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Compile and run the NAND target testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module nandTargetTb -o nandTargetSim

./obj_dir/nandTargetSim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== verification/nandTargetTb.sv ====
//----------------------------------------------------------
// NAND target testbench
// Reference busy model compared with the DUT by assertions
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nandTarget_config.svh"

module nandTargetTb
    import nandCommandPkg::*, nandArrayPkg::*;
();

    localparam int resetCycles = 8;
    localparam int testCycles  = 260 + 180 + 140 + 230 + 520;      // Tests 1 to 5
    localparam int watchdogCycles = resetCycles + testCycles + 200;

    logic clk, reset, ceN, cle, ale, weStrobe;
    opcode_t dq;
    lunMask_t rbN;
    logic multiLunViolation, statusViolation;
    violationCount_t violationCount;

    int valueErrors, otherErrors;
    string testName;
    logic [31:0] rngState;

    // Reference model state
    logic modelLun, sampledValid, sampledLun, effectValid, effectLun;
    opcode_t sampledOp, effectOp;
    busyCount_t modelCnt [`LUN_COUNT];
    lunMask_t modelExcl, modelRbN;
    logic modelMulti, modelStatus;
    violationCount_t modelCount;

    nandTarget uut (.clk(clk), .reset(reset), .ceN(ceN), .cle(cle), .ale(ale),
        .weStrobe(weStrobe), .dq(dq), .rbN(rbN), .multiLunViolation(multiLunViolation),
        .statusViolation(statusViolation), .violationCount(violationCount));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic multiLunOpcode(input opcode_t op);
        case (op)
            8'h00, 8'h05, 8'h06, 8'h10, 8'h11: return 1'b1;
            8'h30, 8'h31, 8'h32, 8'h35, 8'h3F: return 1'b1;
            8'h60, 8'h78, 8'h80, 8'h85, 8'hD0, 8'hD1, 8'hE0: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic busyCount_t busyTimeFor(input opcode_t op);
        case (op)
            8'h30: return busyCount_t'(`READ_BUSY_CYCLES);
            8'h10: return busyCount_t'(`PROGRAM_BUSY_CYCLES);
            8'hD0: return busyCount_t'(`ERASE_BUSY_CYCLES);
            8'hFF: return busyCount_t'(`RESET_BUSY_CYCLES);
            8'h90, 8'hEF: return busyCount_t'(`CONFIG_BUSY_CYCLES);
            default: return '0;
        endcase
    endfunction

    //----------------------------------------------------------
    // Reference model with two edges of command latency
    //----------------------------------------------------------
    always @(posedge clk) begin : referenceModel
        logic multiHit;
        logic statusHit;
        logic wholeTarget;
        multiHit = effectValid && multiLunOpcode(effectOp) && (modelExcl != '0);
        statusHit = effectValid && (effectOp == 8'h70) && (modelRbN == '0) && (modelExcl == '0);
        wholeTarget = (effectOp == 8'hFF) || (effectOp == 8'h90) || (effectOp == 8'hEF);
        if (reset) begin
            {modelLun, sampledValid, effectValid, modelMulti, modelStatus} <= '0;
            modelExcl  <= '0;
            modelCount <= '0;
            for (int i = 0; i < `LUN_COUNT; i++) modelCnt[i] <= '0;
        end else begin
            sampledValid <= weStrobe && !ceN && cle && !ale;
            {sampledOp, sampledLun} <= {dq, modelLun};
            {effectValid, effectOp, effectLun} <= {sampledValid, sampledOp, sampledLun};
            if (weStrobe && !ceN && ale && !cle) modelLun <= dq[`LUN_ADDR_BIT];
            modelMulti  <= multiHit;
            modelStatus <= statusHit;
            if ((multiHit || statusHit) && (modelCount != '1)) modelCount <= modelCount + 1'b1;
            for (int i = 0; i < `LUN_COUNT; i++) begin
                if (modelCnt[i] != '0) begin
                    modelCnt[i] <= modelCnt[i] - 1'b1;             // Starts while busy ignored
                    if (modelCnt[i] == busyCount_t'(1)) modelExcl[i] <= 1'b0;
                end else if (effectValid && (busyTimeFor(effectOp) != '0) &&
                             (wholeTarget || (effectLun == lunIndex_t'(i)))) begin
                    modelCnt[i]  <= busyTimeFor(effectOp);
                    modelExcl[i] <= wholeTarget;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LUN_COUNT; i++) modelRbN[i] = (modelCnt[i] == '0);
    end

    //----------------------------------------------------------
    // Checks
    //----------------------------------------------------------
    readyMatches: assert property (@(posedge clk) disable iff (reset) rbN == modelRbN)
    else begin
        valueErrors++;
        $display("CHECK FAILED %s: rbN expected %b actual %b", testName, modelRbN, rbN);
    end

    violationsMatch: assert property (@(posedge clk) disable iff (reset)
        {multiLunViolation, statusViolation, violationCount} ==
        {modelMulti, modelStatus, modelCount})
    else begin
        valueErrors++;
        $display("CHECK FAILED %s: multi/status/count expected %b/%b/%0d actual %b/%b/%0d",
                 testName, modelMulti, modelStatus, modelCount,
                 multiLunViolation, statusViolation, violationCount);
    end

    resetClears: assert property (@(posedge clk) reset |=>
        (rbN == '1) && !multiLunViolation && !statusViolation && (violationCount == '0))
    else begin
        valueErrors++;
        $display("CHECK FAILED %s: reset rbN/pulses/count expected 11/00/0 actual %b/%b%b/%0d",
                 testName, rbN, multiLunViolation, statusViolation, violationCount);
    end

    task automatic busCycle(input logic ce, input logic c, input logic a,
                            input logic we, input opcode_t d);
        @(posedge clk);
        {ceN, cle, ale, weStrobe} <= {ce, c, a, we};
        dq <= d;
    endtask

    task automatic issueCommand(input opcode_t op);
        busCycle(1'b0, 1'b1, 1'b0, 1'b1, op);
    endtask

    task automatic issueAddress(input lunIndex_t lun);
        opcode_t addr;
        rngState = xorshift(rngState);
        addr = rngState[7:0];
        addr[`LUN_ADDR_BIT] = lun;                      // Random row bits, fixed LUN bit
        busCycle(1'b0, 1'b0, 1'b1, 1'b1, addr);
    endtask

    task automatic driveIdle(input int cycles);
        repeat (cycles) busCycle(1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
    endtask

    // Idle past the two edge rbN latency before polling
    task automatic waitReady(input int limit);
        int waited;
        waited = 0;
        driveIdle(3);
        @(negedge clk);
        while ((rbN != '1) && (waited < limit)) begin
            @(negedge clk);
            waited++;
        end
        if (rbN != '1) begin
            otherErrors++;
            $display("%s: ready/busy did not return high within %0d cycles", testName, limit);
        end
    endtask

    task automatic applyReset();
        busCycle(1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        $display("STATUS: FAIL");
        $finish;
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------
    initial begin
        {reset, ceN, cle, ale, weStrobe} = 5'b11000;
        dq = '0;
        valueErrors = 0;
        otherErrors = 0;
        rngState = 32'hd84bc5cd;
        testName = "powerOnReset";
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        testName = "singleLunBusy";
        for (int k = 0; k < 3; k++) begin
            issueAddress(lunIndex_t'(k[0]));
            issueCommand((k == 0) ? 8'h30 : (k == 1) ? 8'h10 : 8'hD0);
            driveIdle(5);
            issueCommand((k == 0) ? 8'h30 : (k == 1) ? 8'h10 : 8'hD0);   // Second start
            waitReady(80);
        end

        testName = "exclusiveBusy";
        for (int k = 0; k < 3; k++) begin
            issueCommand((k == 0) ? 8'hFF : (k == 1) ? 8'h90 : 8'hEF);
            driveIdle(2);
            issueCommand(8'h00);                         // Multi-LUN
            issueCommand(8'h70);                         // Status during exclusive op
            issueCommand(8'hE0);
            waitReady(40);
        end

        testName = "statusMisuse";
        issueAddress(1'b0);
        issueCommand(8'h30);
        issueAddress(1'b1);
        issueCommand(8'h30);
        driveIdle(3);
        issueCommand(8'h70);                             // Both LUNs reading
        waitReady(40);
        issueAddress(1'b0);
        issueCommand(8'h30);
        driveIdle(3);
        issueCommand(8'h70);                             // One LUN reading
        waitReady(40);

        testName = "ignoredCycles";
        issueAddress(1'b0);
        issueCommand(8'hD0);
        repeat (150) begin
            rngState = xorshift(rngState);
            if (rngState[0]) begin
                busCycle(1'b1, rngState[1], rngState[2], 1'b1, rngState[15:8]);
            end else begin
                busCycle(1'b0, 1'b1, 1'b1, 1'b1, rngState[15:8]);
            end
        end
        waitReady(80);

        testName = "countAndReset";
        repeat (12) begin
            issueCommand(8'hFF);
            repeat (26) issueCommand(8'h00);
            waitReady(40);
        end
        if (modelCount != '1) begin
            otherErrors++;
            $display("%s: violation count never reached its maximum", testName);
        end
        issueAddress(1'b1);
        issueCommand(8'hD0);
        issueCommand(8'hFF);                             // Loads the idle LUN 0 only
        driveIdle(2);
        issueCommand(8'h00);                             // Pulse due as reset rises
        driveIdle(1);
        applyReset();
        driveIdle(4);

        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/nandTarget.sv ====
//----------------------------------------------------------
// NAND target monitor top level
// Command decode, LUN busy model and protocol checks
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nandTarget
    import nandCommandPkg::*, nandArrayPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            ceN,
    input  logic            cle,
    input  logic            ale,
    input  logic            weStrobe,           // Stands in for WE# rising edge
    input  opcode_t         dq,
    output lunMask_t        rbN,
    output logic            multiLunViolation,
    output logic            statusViolation,
    output violationCount_t violationCount
);

    lunMask_t lunBusy;
    lunMask_t lunExclusive;                     // Busy from reset or config

    nandCommandIf commandBus ();

    //----------------------------------------------------------
    // Decode, track, check
    //----------------------------------------------------------
    commandLatchDecoder latchDecoder (
        .clk      (clk),
        .reset    (reset),
        .ceN      (ceN),
        .cle      (cle),
        .ale      (ale),
        .weStrobe (weStrobe),
        .dq       (dq),
        .cmd      (commandBus.decoder)
    );

    lunBusyTracker busyTracker (
        .clk          (clk),
        .reset        (reset),
        .cmd          (commandBus.tracker),
        .rbN          (rbN),
        .lunBusy      (lunBusy),
        .lunExclusive (lunExclusive)
    );

    lunProtocolChecker protocolChecker (
        .clk               (clk),
        .reset             (reset),
        .cmd               (commandBus.monitor),
        .lunBusy           (lunBusy),
        .lunExclusive      (lunExclusive),
        .multiLunViolation (multiLunViolation),
        .statusViolation   (statusViolation),
        .violationCount    (violationCount)
    );

endmodule

`default_nettype wire

// ==== source/lunProtocolChecker.sv ====
//----------------------------------------------------------
// LUN protocol checker
// Flags multi-LUN and read status misuse, counts violations
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lunProtocolChecker
    import nandCommandPkg::*, nandArrayPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    nandCommandIf.monitor   cmd,
    input  lunMask_t        lunBusy,
    input  lunMask_t        lunExclusive,
    output logic            multiLunViolation,
    output logic            statusViolation,
    output violationCount_t violationCount
);

    logic    checkQ;                   // Command stage valid
    opcode_t opcodeQ;
    logic    isMultiLunQ;
    logic    multiHit;
    logic    statusHit;

    //----------------------------------------------------------
    // Command stage aligned with the tracker load edge
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            checkQ <= 1'b0;
        end else begin
            checkQ <= cmd.valid;
        end
    end

    always_ff @(posedge clk) begin
        opcodeQ     <= cmd.opcode;
        isMultiLunQ <= cmd.isMultiLun;
    end

    // Status seen here is the state before this command takes effect
    assign multiHit  = checkQ && isMultiLunQ && (|lunExclusive);
    assign statusHit = checkQ && (opcodeQ == readStatus) &&
                       (&lunBusy) && !(|lunExclusive);   // All LUNs in array ops

    //----------------------------------------------------------
    // Violation pulses and saturating count
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            multiLunViolation <= 1'b0;
            statusViolation   <= 1'b0;
        end else begin
            multiLunViolation <= multiHit;
            statusViolation   <= statusHit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            violationCount <= '0;
        end else if ((multiHit || statusHit) && (violationCount != '1)) begin
            violationCount <= violationCount + 1'b1;    // Holds at all ones
        end
    end

    // Read status is not multi-LUN, and an exclusive LUN masks status misuse
    singleViolation: assert property (
        @(posedge clk) disable iff (reset) !(multiLunViolation && statusViolation)
    ) else $error("Both protocol violations flagged for one command");

endmodule

`default_nettype wire

// ==== source/lunBusyTracker.sv ====
//----------------------------------------------------------
// LUN busy tracker
// Busy countdown and exclusive flag for each LUN
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nandTarget_config.svh"

module lunBusyTracker
    import nandCommandPkg::*, nandArrayPkg::*;
(
    input  logic          clk,
    input  logic          reset,
    nandCommandIf.tracker cmd,
    output lunMask_t      rbN,
    output lunMask_t      lunBusy,
    output lunMask_t      lunExclusive
);

    logic       startQ;                        // Command stage valid
    opKind_t    kindQ;
    lunIndex_t  lunQ;
    logic       targetAll;
    busyCount_t loadValue;
    busyCount_t busyCount [`LUN_COUNT];

    function automatic busyCount_t busyCycles(input opKind_t kind);
        case (kind)
            kindRead:    return busyCount_t'(`READ_BUSY_CYCLES);
            kindProgram: return busyCount_t'(`PROGRAM_BUSY_CYCLES);
            kindErase:   return busyCount_t'(`ERASE_BUSY_CYCLES);
            kindReset:   return busyCount_t'(`RESET_BUSY_CYCLES);
            kindConfig:  return busyCount_t'(`CONFIG_BUSY_CYCLES);
            default:     return '0;
        endcase
    endfunction

    //----------------------------------------------------------
    // Command stage one cycle behind the decoder
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            startQ <= 1'b0;
        end else begin
            startQ <= cmd.valid && (cmd.kind != kindNone);
        end
    end

    always_ff @(posedge clk) begin
        kindQ <= cmd.kind;
        lunQ  <= cmd.lun;
    end

    assign targetAll = (kindQ == kindReset) || (kindQ == kindConfig);   // Whole target
    assign loadValue = busyCycles(kindQ);

    //----------------------------------------------------------
    // Per LUN countdown
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LUN_COUNT; i++) begin
                busyCount[i] <= '0;
            end
            lunExclusive <= '0;
        end else begin
            for (int i = 0; i < `LUN_COUNT; i++) begin
                if (lunBusy[i]) begin
                    busyCount[i] <= busyCount[i] - 1'b1;   // Starts while busy are dropped
                    if (busyCount[i] == busyCount_t'(1)) begin
                        lunExclusive[i] <= 1'b0;
                    end
                end else if (startQ && targetAll) begin
                    busyCount[i]    <= loadValue;
                    lunExclusive[i] <= 1'b1;
                end else if (startQ && (lunQ == lunIndex_t'(i))) begin
                    busyCount[i] <= loadValue;          // Array op on selected LUN
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LUN_COUNT; i++) begin
            lunBusy[i] = (busyCount[i] != '0);
        end
    end

    assign rbN = ~lunBusy;                     // Ready/busy pins, low while busy

    exclusiveIsBusy: assert property (
        @(posedge clk) disable iff (reset) (lunExclusive & ~lunBusy) == '0
    ) else $error("LUN marked exclusive while its countdown is idle");

    // A LUN only goes busy on the load edge of a start
    busyOnlyOnStart: assert property (
        @(posedge clk) disable iff (reset)
        ((~rbN & $past(rbN)) != '0) |-> $past(startQ)
    ) else $error("Ready/busy fell without a command start");

endmodule

`default_nettype wire

// ==== source/commandLatchDecoder.sv ====
//----------------------------------------------------------
// Command latch decoder
// Latches command and address cycles, issues decoded commands
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nandTarget_config.svh"

module commandLatchDecoder
    import nandCommandPkg::*, nandArrayPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ceN,
    input  logic                 cle,
    input  logic                 ale,
    input  logic                 weStrobe,
    input  opcode_t              dq,
    nandCommandIf.decoder        cmd
);

    logic      commandCycle;
    logic      addressCycle;
    lunIndex_t lunSel;                 // LUN of the last address byte

    // Map confirm and reset opcodes to the array operation they start
    function automatic opKind_t kindOf(input opcode_t op);
        case (op)
            readConfirm:                return kindRead;
            programConfirm:             return kindProgram;
            eraseConfirm:               return kindErase;
            resetCommand:               return kindReset;
            readIdCommand, setFeatures: return kindConfig;
            default:                    return kindNone;
        endcase
    endfunction

    //----------------------------------------------------------
    // Bus cycle qualification
    //----------------------------------------------------------
    assign commandCycle = weStrobe && !ceN && cle && !ale;
    assign addressCycle = weStrobe && !ceN && ale && !cle;

    always_ff @(posedge clk) begin
        if (reset) begin
            lunSel <= 1'b0;
        end else if (addressCycle) begin
            lunSel <= dq[`LUN_ADDR_BIT];    // Last address byte wins
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= commandCycle;      // Single cycle pulse
        end
    end

    // Payload follows the latched command byte
    always_ff @(posedge clk) begin
        if (commandCycle) begin
            cmd.opcode     <= dq;
            cmd.kind       <= kindOf(dq);
            cmd.isMultiLun <= isMultiLunCommand(dq);
            cmd.lun        <= lunSel;
        end
    end

    // A decoded command always comes from a qualified command cycle
    validFromStrobe: assert property (
        @(posedge clk) disable iff (reset)
        cmd.valid |-> $past(weStrobe && !ceN && cle && !ale)
    ) else $error("Decoded command without a command latch cycle");

endmodule

`default_nettype wire

// ==== source/nandCommandIf.sv ====
//----------------------------------------------------------
// Decoded command bus
// One accepted command cycle per valid pulse
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface nandCommandIf import nandCommandPkg::*, nandArrayPkg::*; ();

    logic      valid;        // One cycle per command
    opcode_t   opcode;
    opKind_t   kind;         // Array operation started
    logic      isMultiLun;
    lunIndex_t lun;          // From last address cycle

    modport decoder (
        output valid, opcode, kind, isMultiLun, lun
    );

    // Busy tracking needs the operation and its LUN
    modport tracker (
        input valid, kind, lun
    );

    modport monitor (
        input valid, opcode, isMultiLun
    );

endinterface

`default_nettype wire

// ==== source/nandArrayPkg.sv ====
//----------------------------------------------------------
// NAND array package
// LUN selection, busy and violation count types
//----------------------------------------------------------
`default_nettype none

`include "nandTarget_config.svh"

package nandArrayPkg;

    // LUN addressing
    typedef logic lunIndex_t;                      // Picks one of two LUNs
    typedef logic [`LUN_COUNT-1:0] lunMask_t;      // One bit per LUN

    // Busy countdown, up to 63 cycles
    typedef logic [5:0] busyCount_t;

    // Running count of protocol errors
    typedef logic [`COUNT_WIDTH-1:0] violationCount_t;

endpackage

`default_nettype wire

// ==== source/nandCommandPkg.sv ====
//----------------------------------------------------------
// NAND command package
// Opcode and operation types, multi-LUN classification
//----------------------------------------------------------
`default_nettype none

`include "nandTarget_config.svh"

package nandCommandPkg;

    typedef logic [`DQ_WIDTH-1:0] opcode_t;   // One command byte

    // Array operation started by a command
    typedef enum logic [2:0] {
        kindNone,
        kindRead,
        kindProgram,
        kindErase,
        kindReset,
        kindConfig
    } opKind_t;

    //----------------------------------------------------------
    // Opcodes with a meaning to the busy model
    //----------------------------------------------------------
    localparam opcode_t readConfirm    = 8'h30;
    localparam opcode_t programConfirm = 8'h10;
    localparam opcode_t eraseConfirm   = 8'hD0;
    localparam opcode_t resetCommand   = 8'hFF;
    localparam opcode_t readIdCommand  = 8'h90;
    localparam opcode_t setFeatures    = 8'hEF;
    localparam opcode_t readStatus     = 8'h70;

    // Commands that address a LUN on a multi-LUN target
    function automatic logic isMultiLunCommand(input opcode_t op);
        case (op)
            8'h00, 8'h05, 8'h06: return 1'b1;        // Read setup and column change
            8'h10, 8'h11: return 1'b1;               // Program confirms
            8'h30, 8'h31, 8'h32, 8'h35, 8'h3F: begin
                return 1'b1;                         // Read and copyback confirms
            end
            8'h60: return 1'b1;                      // Erase setup
            8'h78: return 1'b1;                      // Read status enhanced
            8'h80, 8'h85: return 1'b1;               // Program setup
            8'hD0, 8'hD1: return 1'b1;
            8'hE0: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/nandTarget_config.svh ====
//----------------------------------------------------------
// NAND target configuration
// Bus width, LUN layout, busy times and counter width
//----------------------------------------------------------
`ifndef NAND_TARGET_CONFIG_SVH
`define NAND_TARGET_CONFIG_SVH

// Data bus and LUN layout
`define DQ_WIDTH 8
`define LUN_COUNT 2

// Address byte bit that picks the LUN
`define LUN_ADDR_BIT 7

//----------------------------------------------------------
// Array busy times in system clock cycles
//----------------------------------------------------------
`define READ_BUSY_CYCLES 20
`define PROGRAM_BUSY_CYCLES 40
`define ERASE_BUSY_CYCLES 60
`define RESET_BUSY_CYCLES 30

// Read ID and set features share one time
`define CONFIG_BUSY_CYCLES 10

// Violation counter
`define COUNT_WIDTH 8

`endif
